/* source/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// First fetch address after reset
`define CPU_RESET_PC 32'hbfc00000
`define CPU_PC_STEP 32'd4
`define CPU_REG_COUNT 32

// Primary opcodes
`define OP_SPECIAL 6'b000000
`define OP_ADDIU 6'b001001
`define OP_SLTI 6'b001010
`define OP_ANDI 6'b001100
`define OP_ORI 6'b001101
`define OP_XORI 6'b001110
`define OP_LUI 6'b001111

// Funct field of SPECIAL
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND 6'b100100
`define FN_OR 6'b100101
`define FN_XOR 6'b100110
`define FN_NOR 6'b100111
`define FN_SLT 6'b101010
`define FN_SLTU 6'b101011

`endif

/* source/cpuPkg.sv */
package cpuPkg;

    // Data and address word
    typedef logic [31:0] wordT;

    // General register number
    typedef logic [4:0] regAddrT;

    // ALU operation codes
    //   0  add
    //   1  subtract
    //   2  and
    //   3  or
    //   4  xor
    //   5  nor
    //   6  pass operand B
    //   7  set on signed less-than
    //   8  set on unsigned less-than
    // Other codes yield zero
    typedef logic [3:0] aluOpT;

    // Instruction SRAM request machine
    typedef enum logic {
        fetchIdle,
        fetchWait
    } fetchStateT;

endpackage

/* source/instructionFetch.sv */
`include "cpu_macros.svh"

module instructionFetch (
    input  logic         clk,
    input  logic         reset,
    output cpuPkg::wordT inst_sram_addr,
    output logic         inst_sram_readen,
    input  cpuPkg::wordT inst_sram_rdata,
    input  logic         inst_sram_valid,
    output logic         fetchValid,
    output cpuPkg::wordT fetchPc,
    output cpuPkg::wordT fetchInstr
);

    cpuPkg::fetchStateT fetchState;
    cpuPkg::wordT       pc;
    logic               accept;

    assign inst_sram_readen = (fetchState == cpuPkg::fetchWait);
    assign inst_sram_addr = pc;
    assign accept = inst_sram_readen && inst_sram_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchState <= cpuPkg::fetchIdle;
            pc <= `CPU_RESET_PC;
        end else begin
            case (fetchState)
                cpuPkg::fetchIdle: begin
                    fetchState <= cpuPkg::fetchWait;
                end
                cpuPkg::fetchWait: begin
                    // Next request goes out right after acceptance
                    if (accept) begin
                        pc <= pc + `CPU_PC_STEP;
                    end
                end
                default: begin
                    fetchState <= cpuPkg::fetchIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fetchPc <= pc;
            fetchInstr <= inst_sram_rdata;
        end
    end

    // Request must hold steady until the memory answers
    holdRequest: assert property (@(posedge clk) disable iff (reset)
        (fetchState == cpuPkg::fetchWait && !inst_sram_valid)
        |=> (inst_sram_readen && $stable(inst_sram_addr)));

endmodule

/* source/registerFile.sv */
`include "cpu_macros.svh"

module registerFile (
    input  logic            clk,
    input  logic            reset,
    input  cpuPkg::regAddrT readAddrA,
    input  cpuPkg::regAddrT readAddrB,
    output cpuPkg::wordT    readDataA,
    output cpuPkg::wordT    readDataB,
    input  cpuPkg::regAddrT writeAddr,
    input  cpuPkg::wordT    writeData
);

    // Register zero has no storage
    cpuPkg::wordT regs [1:`CPU_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    // A written register reads back on the next cycle
    readBackA: assert property (@(posedge clk) disable iff (reset)
        (writeAddr != '0) |=>
        (readAddrA != $past(writeAddr) || readDataA == $past(writeData)));

    readBackB: assert property (@(posedge clk) disable iff (reset)
        (writeAddr != '0) |=>
        (readAddrB != $past(writeAddr) || readDataB == $past(writeData)));

endmodule

/* source/decodeStage.sv */
`include "cpu_macros.svh"

module decodeStage (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetchValid,
    input  cpuPkg::wordT    fetchPc,
    input  cpuPkg::wordT    fetchInstr,
    output cpuPkg::regAddrT rfReadAddrA,
    output cpuPkg::regAddrT rfReadAddrB,
    input  cpuPkg::wordT    rfReadDataA,
    input  cpuPkg::wordT    rfReadDataB,
    input  cpuPkg::regAddrT fwdExDest,
    input  cpuPkg::wordT    fwdExData,
    input  cpuPkg::regAddrT rfWriteAddr,
    input  cpuPkg::wordT    rfWriteData,
    output logic            exValid,
    output cpuPkg::wordT    exPc,
    output cpuPkg::regAddrT exDest,
    output cpuPkg::aluOpT   exAluOp,
    output cpuPkg::wordT    exOperandA,
    output cpuPkg::wordT    exOperandB
);

    logic [5:0]      opcode;
    logic [5:0]      funct;
    cpuPkg::regAddrT rs;
    cpuPkg::regAddrT rt;
    cpuPkg::regAddrT rd;
    logic [15:0]     imm;
    cpuPkg::aluOpT   aluOp;
    cpuPkg::regAddrT dest;
    logic            useImm;
    cpuPkg::wordT    immValue;
    cpuPkg::wordT    operandA;
    cpuPkg::wordT    operandB;

    assign opcode = fetchInstr[31:26];
    assign rs = fetchInstr[25:21];
    assign rt = fetchInstr[20:16];
    assign rd = fetchInstr[15:11];
    assign funct = fetchInstr[5:0];
    assign imm = fetchInstr[15:0];

    always_comb begin
        aluOp = 4'd0;
        dest = '0;
        useImm = 1'b1;
        immValue = {{16{imm[15]}}, imm};
        if (opcode == `OP_SPECIAL) begin
            useImm = 1'b0;
            dest = rd;
            case (funct)
                `FN_ADDU: aluOp = 4'd0;
                `FN_SUBU: aluOp = 4'd1;
                `FN_AND:  aluOp = 4'd2;
                `FN_OR:   aluOp = 4'd3;
                `FN_XOR:  aluOp = 4'd4;
                `FN_NOR:  aluOp = 4'd5;
                `FN_SLT:  aluOp = 4'd7;
                `FN_SLTU: aluOp = 4'd8;
                default:  dest = '0;
            endcase
        end else begin
            dest = rt;
            case (opcode)
                `OP_ADDIU: aluOp = 4'd0;
                `OP_SLTI:  aluOp = 4'd7;
                `OP_ANDI: begin
                    aluOp = 4'd2;
                    immValue = {16'h0000, imm};
                end
                `OP_ORI: begin
                    aluOp = 4'd3;
                    immValue = {16'h0000, imm};
                end
                `OP_XORI: begin
                    aluOp = 4'd4;
                    immValue = {16'h0000, imm};
                end
                `OP_LUI: begin
                    aluOp = 4'd6;
                    immValue = {imm, 16'h0000};
                end
                // Unknown encodings retire as bubbles
                default: dest = '0;
            endcase
        end
    end

    // Execute result is newest, then the write port, then the file
    function automatic cpuPkg::wordT pickOperand(
        input cpuPkg::regAddrT addr,
        input cpuPkg::wordT    fileValue,
        input cpuPkg::regAddrT newDest,
        input cpuPkg::wordT    newData,
        input cpuPkg::regAddrT oldDest,
        input cpuPkg::wordT    oldData
    );
        if (addr == '0) begin
            return '0;
        end
        if (addr == newDest) begin
            return newData;
        end
        if (addr == oldDest) begin
            return oldData;
        end
        return fileValue;
    endfunction

    assign rfReadAddrA = rs;
    assign rfReadAddrB = rt;
    assign operandA = pickOperand(rs, rfReadDataA, fwdExDest, fwdExData,
                                  rfWriteAddr, rfWriteData);
    assign operandB = pickOperand(rt, rfReadDataB, fwdExDest, fwdExData,
                                  rfWriteAddr, rfWriteData);

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end else begin
            exValid <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        exPc <= fetchPc;
        exDest <= dest;
        exAluOp <= aluOp;
        exOperandA <= operandA;
        exOperandB <= useImm ? immValue : operandB;
    end

endmodule

/* source/executeStage.sv */
module executeStage (
    input  logic            clk,
    input  logic            reset,
    input  logic            exValid,
    input  cpuPkg::wordT    exPc,
    input  cpuPkg::regAddrT exDest,
    input  cpuPkg::aluOpT   exAluOp,
    input  cpuPkg::wordT    exOperandA,
    input  cpuPkg::wordT    exOperandB,
    output cpuPkg::regAddrT fwdExDest,
    output cpuPkg::wordT    fwdExData,
    output logic            resValid,
    output cpuPkg::wordT    resPc,
    output cpuPkg::regAddrT resDest,
    output cpuPkg::wordT    resData
);

    cpuPkg::wordT aluResult;
    logic         signedLess;
    logic         unsignedLess;

    assign signedLess = $signed(exOperandA) < $signed(exOperandB);
    assign unsignedLess = exOperandA < exOperandB;

    always_comb begin
        case (exAluOp)
            4'd0: aluResult = exOperandA + exOperandB;
            4'd1: aluResult = exOperandA - exOperandB;
            4'd2: aluResult = exOperandA & exOperandB;
            4'd3: aluResult = exOperandA | exOperandB;
            4'd4: aluResult = exOperandA ^ exOperandB;
            4'd5: aluResult = ~(exOperandA | exOperandB);
            4'd6: aluResult = exOperandB;
            4'd7: aluResult = {31'b0, signedLess};
            4'd8: aluResult = {31'b0, unsignedLess};
            default: aluResult = '0;
        endcase
    end

    // A bubble must not match any decode source
    assign fwdExDest = exValid ? exDest : '0;
    assign fwdExData = aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            resValid <= 1'b0;
        end else begin
            resValid <= exValid;
        end
    end

    always_ff @(posedge clk) begin
        resPc <= exPc;
        resDest <= exDest;
        resData <= aluResult;
    end

    // Operands forwarded by decode must be resolved by now
    knownResult: assert property (@(posedge clk) disable iff (reset)
        exValid |-> !$isunknown(aluResult));

endmodule

/* source/resultStage.sv */
module resultStage (
    input  logic            resValid,
    input  cpuPkg::wordT    resPc,
    input  cpuPkg::regAddrT resDest,
    input  cpuPkg::wordT    resData,
    output cpuPkg::regAddrT rfWriteAddr,
    output cpuPkg::wordT    rfWriteData,
    output cpuPkg::wordT    debug_wb_pc,
    output logic [3:0]      debug_wb_rf_wen,
    output cpuPkg::regAddrT debug_wb_rf_wnum,
    output cpuPkg::wordT    debug_wb_rf_wdata
);

    // Bubbles write register zero, which is ignored
    assign rfWriteAddr = resValid ? resDest : '0;
    assign rfWriteData = resData;

    // Trace shows all byte enables on a real write
    assign debug_wb_pc = resPc;
    assign debug_wb_rf_wen = (rfWriteAddr != '0) ? 4'b1111 : 4'b0000;
    assign debug_wb_rf_wnum = rfWriteAddr;
    assign debug_wb_rf_wdata = rfWriteData;

endmodule

/* source/cpuCore.sv */
module cpuCore (
    input  logic            clk,
    input  logic            reset,
    output cpuPkg::wordT    inst_sram_addr,
    output logic            inst_sram_readen,
    input  cpuPkg::wordT    inst_sram_rdata,
    input  logic            inst_sram_valid,
    output cpuPkg::wordT    debug_wb_pc,
    output logic [3:0]      debug_wb_rf_wen,
    output cpuPkg::regAddrT debug_wb_rf_wnum,
    output cpuPkg::wordT    debug_wb_rf_wdata
);

    logic            fetchValid;
    cpuPkg::wordT    fetchPc;
    cpuPkg::wordT    fetchInstr;
    cpuPkg::regAddrT rfReadAddrA;
    cpuPkg::regAddrT rfReadAddrB;
    cpuPkg::wordT    rfReadDataA;
    cpuPkg::wordT    rfReadDataB;
    cpuPkg::regAddrT rfWriteAddr;
    cpuPkg::wordT    rfWriteData;
    logic            exValid;
    cpuPkg::wordT    exPc;
    cpuPkg::regAddrT exDest;
    cpuPkg::aluOpT   exAluOp;
    cpuPkg::wordT    exOperandA;
    cpuPkg::wordT    exOperandB;
    cpuPkg::regAddrT fwdExDest;
    cpuPkg::wordT    fwdExData;
    logic            resValid;
    cpuPkg::wordT    resPc;
    cpuPkg::regAddrT resDest;
    cpuPkg::wordT    resData;

    instructionFetch fetch (
        .clk(clk),
        .reset(reset),
        .inst_sram_addr(inst_sram_addr),
        .inst_sram_readen(inst_sram_readen),
        .inst_sram_rdata(inst_sram_rdata),
        .inst_sram_valid(inst_sram_valid),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .fetchInstr(fetchInstr)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .readAddrA(rfReadAddrA),
        .readAddrB(rfReadAddrB),
        .readDataA(rfReadDataA),
        .readDataB(rfReadDataB),
        .writeAddr(rfWriteAddr),
        .writeData(rfWriteData)
    );

    decodeStage decode (
        .clk(clk),
        .reset(reset),
        .fetchValid(fetchValid),
        .fetchPc(fetchPc),
        .fetchInstr(fetchInstr),
        .rfReadAddrA(rfReadAddrA),
        .rfReadAddrB(rfReadAddrB),
        .rfReadDataA(rfReadDataA),
        .rfReadDataB(rfReadDataB),
        .fwdExDest(fwdExDest),
        .fwdExData(fwdExData),
        .rfWriteAddr(rfWriteAddr),
        .rfWriteData(rfWriteData),
        .exValid(exValid),
        .exPc(exPc),
        .exDest(exDest),
        .exAluOp(exAluOp),
        .exOperandA(exOperandA),
        .exOperandB(exOperandB)
    );

    executeStage execute (
        .clk(clk),
        .reset(reset),
        .exValid(exValid),
        .exPc(exPc),
        .exDest(exDest),
        .exAluOp(exAluOp),
        .exOperandA(exOperandA),
        .exOperandB(exOperandB),
        .fwdExDest(fwdExDest),
        .fwdExData(fwdExData),
        .resValid(resValid),
        .resPc(resPc),
        .resDest(resDest),
        .resData(resData)
    );

    resultStage result (
        .resValid(resValid),
        .resPc(resPc),
        .resDest(resDest),
        .resData(resData),
        .rfWriteAddr(rfWriteAddr),
        .rfWriteData(rfWriteData),
        .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

/* test/instrMemModel.sv */
`include "cpu_macros.svh"

module instrMemModel #(
    parameter int progWords = 200
) (
    input  logic         clk,
    input  logic         reset,
    input  cpuPkg::wordT addr,
    input  logic         readEn,
    output cpuPkg::wordT readData,
    output logic         valid,
    output logic         requestError,
    output cpuPkg::wordT expectedAddr,
    output cpuPkg::wordT seenAddr
);

    cpuPkg::wordT progMem [0:progWords-1];

    // Mostly supported encodings on registers 0 to 7 so dependencies are dense
    task automatic fillProgram();
        int              kind;
        cpuPkg::regAddrT rs;
        cpuPkg::regAddrT rt;
        cpuPkg::regAddrT rd;
        logic [15:0]     imm;
        logic [5:0]      op;
        logic [5:0]      fn;
        for (int i = 0; i < progWords; i++) begin
            rs = $urandom_range(7, 0);
            rt = $urandom_range(7, 0);
            rd = $urandom_range(7, 0);
            imm = $urandom();
            kind = $urandom_range(13, 0);
            op = `OP_SPECIAL;
            fn = `FN_ADDU;
            case (kind)
                0: fn = `FN_ADDU;
                1: fn = `FN_SUBU;
                2: fn = `FN_AND;
                3: fn = `FN_OR;
                4: fn = `FN_XOR;
                5: fn = `FN_NOR;
                6: fn = `FN_SLT;
                7: fn = `FN_SLTU;
                8: op = `OP_ADDIU;
                9: op = `OP_SLTI;
                10: op = `OP_ANDI;
                11: op = `OP_ORI;
                12: op = `OP_XORI;
                default: op = `OP_LUI;
            endcase
            if ($urandom_range(99, 0) >= 80) begin
                progMem[i] = $urandom();
            end else if (kind < 8) begin
                progMem[i] = {op, rs, rt, rd, 5'b00000, fn};
            end else begin
                progMem[i] = {op, rs, rt, imm};
            end
        end
    endtask

    function automatic cpuPkg::wordT wordAt(input cpuPkg::wordT a);
        cpuPkg::wordT offset;
        offset = a - `CPU_RESET_PC;
        if (offset < progWords * 4) begin
            return progMem[offset >> 2];
        end
        // Past the program an unknown opcode is mixed with the address
        return {6'h3f, a[25:0] ^ a[31:6]};
    endfunction

    initial begin
        int delay;
        valid = 1'b0;
        readData = '0;
        requestError = 1'b0;
        expectedAddr = `CPU_RESET_PC;
        seenAddr = '0;
        @(negedge clk);
        forever begin
            if (reset || readEn !== 1'b1) begin
                @(negedge clk);
            end else begin
                if (addr !== expectedAddr && !requestError) begin
                    requestError = 1'b1;
                    seenAddr = addr;
                end
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                valid = 1'b1;
                readData = wordAt(addr);
                @(negedge clk);
                valid = 1'b0;
                expectedAddr = expectedAddr + `CPU_PC_STEP;
            end
        end
    end

endmodule

/* test/cpuTb.sv */
`include "cpu_macros.svh"

module cpuTb;

    localparam int progWords = 200;
    localparam int writeTimeout = 50;
    localparam int quietCycles = 30;

    logic            clk;
    logic            reset;
    cpuPkg::wordT    instAddr;
    logic            instReadEn;
    cpuPkg::wordT    instData;
    logic            instValid;
    cpuPkg::wordT    wbPc;
    logic [3:0]      wbWen;
    cpuPkg::regAddrT wbWnum;
    cpuPkg::wordT    wbWdata;
    logic            requestError;
    cpuPkg::wordT    expectedAddr;
    cpuPkg::wordT    seenAddr;
    cpuPkg::wordT    shadow [0:31];

    cpuCore uut (
        .clk(clk),
        .reset(reset),
        .inst_sram_addr(instAddr),
        .inst_sram_readen(instReadEn),
        .inst_sram_rdata(instData),
        .inst_sram_valid(instValid),
        .debug_wb_pc(wbPc),
        .debug_wb_rf_wen(wbWen),
        .debug_wb_rf_wnum(wbWnum),
        .debug_wb_rf_wdata(wbWdata)
    );

    instrMemModel #(.progWords(progWords)) imem (
        .clk(clk),
        .reset(reset),
        .addr(instAddr),
        .readEn(instReadEn),
        .readData(instData),
        .valid(instValid),
        .requestError(requestError),
        .expectedAddr(expectedAddr),
        .seenAddr(seenAddr)
    );

    always #2 clk = ~clk;

    task automatic stopWithFailure();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input cpuPkg::wordT expected,
                                  input cpuPkg::wordT actual);
        $display("FAIL %s expected %h actual %h", name, expected, actual);
        stopWithFailure();
    endtask

    task automatic reportProblem(input string what);
        $display("%s", what);
        stopWithFailure();
    endtask

    // Architectural result of one instruction against the shadow registers
    function automatic cpuPkg::regAddrT refExecute(input cpuPkg::wordT instr,
                                                   output cpuPkg::wordT value);
        cpuPkg::wordT    a;
        cpuPkg::wordT    b;
        cpuPkg::wordT    sImm;
        cpuPkg::wordT    zImm;
        cpuPkg::regAddrT dest;
        a = shadow[instr[25:21]];
        b = shadow[instr[20:16]];
        sImm = {{16{instr[15]}}, instr[15:0]};
        zImm = {16'h0000, instr[15:0]};
        value = '0;
        if (instr[31:26] == `OP_SPECIAL) begin
            dest = instr[15:11];
            case (instr[5:0])
                `FN_ADDU: value = a + b;
                `FN_SUBU: value = a - b;
                `FN_AND: value = a & b;
                `FN_OR: value = a | b;
                `FN_XOR: value = a ^ b;
                `FN_NOR: value = ~(a | b);
                `FN_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `FN_SLTU: value = (a < b) ? 32'd1 : 32'd0;
                default: dest = '0;
            endcase
        end else begin
            dest = instr[20:16];
            case (instr[31:26])
                `OP_ADDIU: value = a + sImm;
                `OP_SLTI: value = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                `OP_ANDI: value = a & zImm;
                `OP_ORI: value = a | zImm;
                `OP_XORI: value = a ^ zImm;
                `OP_LUI: value = {instr[15:0], 16'h0000};
                default: dest = '0;
            endcase
        end
        return dest;
    endfunction

    // Walks the program in order, one retired write per expected write
    task automatic checkRetirements();
        cpuPkg::regAddrT dest;
        cpuPkg::wordT    value;
        cpuPkg::wordT    pc;
        int              waited;
        for (int i = 0; i < progWords; i++) begin
            dest = refExecute(imem.progMem[i], value);
            pc = `CPU_RESET_PC + i * 4;
            if (dest != '0) begin
                shadow[dest] = value;
                waited = 0;
                @(negedge clk);
                while (wbWen === 4'b0000 && waited < writeTimeout) begin
                    @(negedge clk);
                    waited++;
                end
                assert (wbWen !== 4'b0000) else begin
                    reportProblem($sformatf("No register write seen for instruction at %h", pc));
                end
                assert (wbWen === 4'b1111) else begin
                    reportMismatch("debug_wb_rf_wen", 32'hf, {28'h0, wbWen});
                end
                assert (wbPc === pc) else begin
                    reportMismatch("debug_wb_pc", pc, wbPc);
                end
                assert (wbWnum === dest) else begin
                    reportMismatch("debug_wb_rf_wnum", {27'h0, dest}, {27'h0, wbWnum});
                end
                assert (wbWdata === value) else begin
                    reportMismatch("debug_wb_rf_wdata", value, wbWdata);
                end
            end
        end
    endtask

    // Trailing bubbles and fill words must write nothing
    task automatic checkQuiet();
        repeat (quietCycles) begin
            @(negedge clk);
            assert (wbWen === 4'b0000) else begin
                reportProblem("A register write appeared after the last expected write");
            end
        end
    endtask

    always @(posedge clk) begin
        assert (requestError !== 1'b1) else begin
            reportMismatch("inst_sram_addr", expectedAddr, seenAddr);
        end
    end

    initial begin
        int seed;
        seed = 79985;
        void'($urandom(seed));
        clk = 1'b0;
        reset = 1'b1;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        imem.fillProgram();
        repeat (5) begin
            @(negedge clk);
            assert (instReadEn === 1'b0) else begin
                reportProblem("Instruction read enable was not low during reset");
            end
            assert (wbWen === 4'b0000) else begin
                reportMismatch("debug_wb_rf_wen", 32'h0, {28'h0, wbWen});
            end
        end
        reset = 1'b0;
        checkRetirements();
        checkQuiet();
        $display("Test OK");
        $finish;
    end

endmodule

/* tb.f */
+incdir+source
source/cpuPkg.sv
source/instructionFetch.sv
source/registerFile.sv
source/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/cpuCore.sv
test/instrMemModel.sv
test/cpuTb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - target: rtl
    include_dirs:
      - source
    files:
      - source/cpuPkg.sv
      - source/instructionFetch.sv
      - source/registerFile.sv
      - source/decodeStage.sv
      - source/executeStage.sv
      - source/resultStage.sv
      - source/cpuCore.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/instrMemModel.sv
      - test/cpuTb.sv
